// ==== tb.f ====
design/mem_map_pkg.sv
design/cart_pkg.sv
design/bank_table.sv
design/bus_events.sv
design/cart_mapper.sv
design/addr_translate.sv
design/cartridge_top.sv
bench/cartridge_properties.sv
bench/cartridge_tb.sv

// ==== Makefile ====
# Cartridge banking controller, Verilator simulation

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module cartridge_tb -Mdir obj_dir
	obj_dir/Vcartridge_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/cartridge_tb.sv ====
// Cartridge controller testbench
// Runs a table of CRT loads, bus accesses and checks through the banking
// controller for the Generic, Simons, Ocean, Magic Desk and EasyFlash types

module cartridge_tb;
	import mem_map_pkg::*;
	import cart_pkg::*;

	typedef enum logic [1:0] {op_cart, op_load, op_bus, op_check} op_e;
	typedef enum logic [2:0] {w_none, w_roml, w_romh, w_io1, w_io2} win_e;

	// One table row, each operation uses only the fields it needs
	typedef struct packed {
		op_e               op;
		cart_type_e        id;          // Cart rows
		logic [7:0]        exrom_line;
		logic [7:0]        game_line;
		bank_rec_t         rec;         // Load rows
		cpu_bus_t          bus;         // Bus and check rows
		logic              exp_exrom;
		logic              exp_game;
		logic [addr_w-1:0] exp_addr;
		logic              exp_ce;
		logic              exp_wr;
	} row_t;

	logic              clk32 = 1'b0;
	logic              reset_n;
	logic              cart_loading;
	cart_type_e        cart_id;
	logic [7:0]        cart_exrom;
	logic [7:0]        cart_game;
	bank_rec_t         cart_bank;
	logic              cart_bank_wr;
	cpu_bus_t          cpu_bus;
	logic              exrom;
	logic              game;
	logic [addr_w-1:0] addr_out;
	logic              mem_write_out;
	logic              mem_ce_out;

	row_t rows[$];
	int   errors = 0;
	int   checks = 0;
	int   cycles = 0;
	int   cycle_limit;

	cartridge_top DUT (
		.clk32(clk32), .reset_n(reset_n), .cart_loading(cart_loading),
		.cart_id(cart_id), .cart_exrom(cart_exrom), .cart_game(cart_game),
		.cart_bank(cart_bank), .cart_bank_wr(cart_bank_wr), .cpu_bus(cpu_bus),
		.exrom(exrom), .game(game), .addr_out(addr_out),
		.mem_write_out(mem_write_out), .mem_ce_out(mem_ce_out)
	);

	always #4 clk32 = ~clk32;

	// ROM banks start at 0x100000, RAM banks at 0x010000, 8k apiece
	function automatic logic [addr_w-1:0] rom_addr(input logic [6:0] bank, input logic [15:0] a);
		return 25'h10_0000 + 25'({bank, 13'h0000}) + 25'(a[12:0]);
	endfunction

	function automatic logic [addr_w-1:0] ram_addr(input logic [6:0] bank, input logic [15:0] a);
		return 25'h01_0000 + 25'({bank[2:0], 13'h0000}) + 25'(a[12:0]);
	endfunction

	function automatic cpu_bus_t make_bus(input win_e win, input logic [15:0] addr,
		input logic write, input logic [7:0] data);
		cpu_bus_t b;
		b = '0;
		b.addr = addr;
		b.data = data;
		b.write = write;
		b.roml = (win == w_roml);
		b.romh = (win == w_romh);
		b.io1 = (win == w_io1);
		b.io2 = (win == w_io2);
		b.ce = b.roml | b.romh;  // IO cycles carry no ce
		return b;
	endfunction

	// ******************************************************************
	// Row builders
	// ******************************************************************
	task automatic load_row(input logic [15:0] num, input logic [15:0] load_addr,
		input logic [15:0] size, input logic [6:0] bank);
		row_t r;
		r = '0;
		r.op = op_load;
		r.rec.load_addr = load_addr;
		r.rec.size = size;
		r.rec.num = num;
		r.rec.raddr = rom_addr(bank, 16'h0000);  // Bank lands in bits 19:13
		rows.push_back(r);
	endtask

	task automatic cart_row(input cart_type_e id, input logic [7:0] ex, input logic [7:0] gm);
		row_t r;
		r = '0;
		r.op = op_cart;
		r.id = id;
		r.exrom_line = ex;
		r.game_line = gm;
		rows.push_back(r);
	endtask

	task automatic bus_row(input win_e win, input logic [15:0] addr, input logic write,
		input logic [7:0] data);
		row_t r;
		r = '0;
		r.op = op_bus;
		r.bus = make_bus(win, addr, write, data);
		rows.push_back(r);
	endtask

	task automatic idle_row();
		bus_row(w_none, 16'h0000, 1'b0, 8'h00);
	endtask

	task automatic check_row(input win_e win, input logic [15:0] addr, input logic write,
		input logic ex, input logic gm, input logic [addr_w-1:0] a, input logic ce,
		input logic wr);
		row_t r;
		r = '0;
		r.op = op_check;
		r.bus = make_bus(win, addr, write, 8'h5a);
		r.exp_exrom = ex;
		r.exp_game = gm;
		r.exp_addr = a;
		r.exp_ce = ce;
		r.exp_wr = wr;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Generic, two packets at 8000, lines from bit 0
		load_row(16'd0, 16'h8000, 16'h4000, 7'd2);
		load_row(16'd1, 16'h8000, 16'h2000, 7'd4);
		cart_row(generic, 8'h02, 8'h13);
		idle_row();
		check_row(w_roml, 16'h8123, 1'b0, 1'b0, 1'b1, rom_addr(7'd2, 16'h8123), 1'b1, 1'b0);
		check_row(w_romh, 16'ha456, 1'b0, 1'b0, 1'b1, rom_addr(7'd3, 16'ha456), 1'b1, 1'b0);

		// Simons Basic
		cart_row(simons, 8'h00, 8'h00);
		idle_row();
		bus_row(w_io1, 16'hde00, 1'b0, 8'h00);
		check_row(w_romh, 16'ha010, 1'b0, 1'b0, 1'b1, rom_addr(7'd1, 16'ha010), 1'b1, 1'b0);
		bus_row(w_io1, 16'hde00, 1'b1, 8'h00);
		check_row(w_romh, 16'ha010, 1'b0, 1'b0, 1'b0, rom_addr(7'd1, 16'ha010), 1'b1, 1'b0);
		bus_row(w_io1, 16'hde00, 1'b0, 8'h00);
		check_row(w_romh, 16'ha010, 1'b0, 1'b0, 1'b1, rom_addr(7'd1, 16'ha010), 1'b1, 1'b0);

		// Ocean, then a 512k image
		cart_row(ocean, 8'h00, 8'h00);
		idle_row();
		check_row(w_roml, 16'h8000, 1'b0, 1'b0, 1'b0, rom_addr(7'd0, 16'h8000), 1'b1, 1'b0);
		bus_row(w_io1, 16'hde00, 1'b1, 8'h05);
		check_row(w_roml, 16'h8abc, 1'b0, 1'b0, 1'b0, rom_addr(7'd5, 16'h8abc), 1'b1, 1'b0);
		check_row(w_romh, 16'ha001, 1'b0, 1'b0, 1'b0, rom_addr(7'd5, 16'ha001), 1'b1, 1'b0);
		load_row(16'd0, 16'h8000, 16'h2000, 7'd0);
		load_row(16'd40, 16'h8000, 16'h2000, 7'd40);
		cart_row(ocean, 8'h00, 8'h00);
		check_row(w_roml, 16'h8010, 1'b0, 1'b0, 1'b1, rom_addr(7'd0, 16'h8010), 1'b1, 1'b0);

		// Magic Desk, a ROML write outside Ultimax reaches memory
		cart_row(magic_desk, 8'h00, 8'h00);
		idle_row();
		check_row(w_roml, 16'h8000, 1'b0, 1'b0, 1'b1, rom_addr(7'd0, 16'h8000), 1'b1, 1'b0);
		check_row(w_roml, 16'h8200, 1'b1, 1'b0, 1'b1, 25'h000_8200, 1'b1, 1'b1);
		bus_row(w_io1, 16'hde00, 1'b1, 8'h83);
		check_row(w_roml, 16'h9fff, 1'b0, 1'b1, 1'b1, rom_addr(7'd3, 16'h9fff), 1'b1, 1'b0);

		// EasyFlash, the new bank shows two cycles after the DE00 write
		load_row(16'd0, 16'h8000, 16'h4000, 7'd8);
		load_row(16'd5, 16'h8000, 16'h2000, 7'd20);
		load_row(16'd5, 16'ha000, 16'h2000, 7'd21);
		cart_row(easyflash, 8'h00, 8'h00);
		idle_row();
		check_row(w_roml, 16'h8100, 1'b0, 1'b1, 1'b0, rom_addr(7'd8, 16'h8100), 1'b1, 1'b0);
		check_row(w_roml, 16'h8100, 1'b1, 1'b1, 1'b0, 25'h000_8100, 1'b1, 1'b0);  // Ultimax
		bus_row(w_io1, 16'hde00, 1'b1, 8'h05);
		check_row(w_roml, 16'h8004, 1'b0, 1'b1, 1'b0, rom_addr(7'd8, 16'h8004), 1'b1, 1'b0);
		check_row(w_roml, 16'h8004, 1'b0, 1'b1, 1'b0, rom_addr(7'd20, 16'h8004), 1'b1, 1'b0);
		check_row(w_romh, 16'he200, 1'b0, 1'b1, 1'b0, rom_addr(7'd21, 16'he200), 1'b1, 1'b0);
		bus_row(w_io1, 16'hde02, 1'b1, 8'h07);
		check_row(w_roml, 16'h8004, 1'b0, 1'b0, 1'b0, rom_addr(7'd20, 16'h8004), 1'b1, 1'b0);
		bus_row(w_io1, 16'hde02, 1'b1, 8'h06);
		check_row(w_roml, 16'h8004, 1'b0, 1'b0, 1'b1, rom_addr(7'd20, 16'h8004), 1'b1, 1'b0);
		check_row(w_io2, 16'hdf12, 1'b1, 1'b0, 1'b1, ram_addr(7'd0, 16'hdf12), 1'b1, 1'b1);
		check_row(w_io2, 16'hdf12, 1'b1, 1'b0, 1'b1, ram_addr(7'd0, 16'hdf12), 1'b0, 1'b1);
	endtask

	// ******************************************************************
	// Drive and compare
	// ******************************************************************
	task automatic apply_row(input row_t r);
		cpu_bus = r.bus;
		cart_bank = r.rec;
		cart_bank_wr = (r.op == op_load);
		if (r.op == op_load)
			cart_loading = 1'b1;
		if (r.op == op_cart) begin
			cart_loading = 1'b0;  // Load done, new id
			cart_id = r.id;
			cart_exrom = r.exrom_line;
			cart_game = r.game_line;
		end
	endtask

	task automatic compare(input string name, input logic [addr_w-1:0] got,
		input logic [addr_w-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic verify_outputs(input logic ex, input logic gm, input logic [addr_w-1:0] a,
		input logic ce, input logic wr);
		compare("exrom", 25'(exrom), 25'(ex));
		compare("game", 25'(game), 25'(gm));
		compare("addr_out", addr_out, a);
		compare("mem_ce_out", 25'(mem_ce_out), 25'(ce));
		compare("mem_write_out", 25'(mem_write_out), 25'(wr));
	endtask

	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: no end of the table after %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		reset_n = 1'b1;
		cart_loading = 1'b0;
		cart_id = magic_desk;  // Not generic, so the first cart row restarts
		cart_exrom = 8'h00;
		cart_game = 8'h00;
		cart_bank = '0;
		cart_bank_wr = 1'b0;
		cpu_bus = '0;
		build_table();
		cycle_limit = 4 * rows.size() + 20;

		// Map is transparent while reset is high
		@(negedge clk32);
		cpu_bus = make_bus(w_roml, 16'h8123, 1'b0, 8'h00);
		#2;
		verify_outputs(1'b1, 1'b1, 25'h000_8123, 1'b1, 1'b0);
		@(negedge clk32);
		reset_n = 1'b0;
		cpu_bus = '0;

		foreach (rows[i]) begin
			@(negedge clk32);
			apply_row(rows[i]);
			if (rows[i].op == op_check) begin
				#2;
				verify_outputs(rows[i].exp_exrom, rows[i].exp_game, rows[i].exp_addr,
					rows[i].exp_ce, rows[i].exp_wr);
			end
		end

		@(negedge clk32);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== bench/cartridge_properties.sv ====
// Cartridge mapper assertions
// Restart sequence and IO1 strobe decode, bound into the mapper

module cartridge_properties (
	input logic                 clk32,
	input cart_pkg::cart_type_e cart_id,
	input cart_pkg::bus_event_t ev,
	input cart_pkg::map_ctrl_t  ctrl,
	input logic                 init_step
);
	import cart_pkg::*;

	// ******************************************************************
	// Restart
	// ******************************************************************

	// Reset is one source of restart, so this covers the cycle after reset
	restart_map: assert property (@(posedge clk32) ev.restart |=> (ctrl.exrom && ctrl.game))
		else $error("EXROM or GAME low in the cycle after restart");

	// Init step follows restart and opens the EasyFlash IO2 RAM by restart+2
	restart_init: assert property (@(posedge clk32)
		$past(ev.restart) && !ev.restart && (cart_id == easyflash || cart_id == xbank)
		|=> $past(init_step) && ctrl.io2_ena && ctrl.io2_wr_ena)
		else $error("init step missing after restart");

	// ******************************************************************
	// IO1 decode
	// ******************************************************************
	io1_dir: assert property (@(posedge clk32) !(ev.io1_wr && ev.io1_rd))
		else $error("IO1 access decoded as read and write at once");

endmodule

bind cart_mapper cartridge_properties u_properties (
	.clk32(clk32),
	.cart_id(cart_id),
	.ev(ev),
	.ctrl(ctrl),
	.init_step(init_step)
);

// ==== design/cartridge_top.sv ====
// C64 cartridge banking controller
// Holds the bank table filled from the CRT image, follows the cartridge
// registers and maps CPU accesses into the SDRAM copy of the image

module cartridge_top (
	input  logic                           clk32,
	input  logic                           reset_n,

	// CRT loading
	input  logic                           cart_loading,
	input  cart_pkg::cart_type_e           cart_id,
	input  logic [7:0]                     cart_exrom,
	input  logic [7:0]                     cart_game,
	input  cart_pkg::bank_rec_t            cart_bank,
	input  logic                           cart_bank_wr,

	// Live CPU bus
	input  mem_map_pkg::cpu_bus_t          cpu_bus,
	output logic                           exrom,
	output logic                           game,
	output logic [mem_map_pkg::addr_w-1:0] addr_out,
	output logic                           mem_write_out,
	output logic                           mem_ce_out
);
	import mem_map_pkg::*;
	import cart_pkg::*;

	logic [idx_w-1:0]  lo_index;
	logic [idx_w-1:0]  hi_index;
	logic [bank_w-1:0] lo_bank;
	logic [bank_w-1:0] hi_bank;
	logic              ocean_b_seen;
	bus_event_t        ev;
	map_ctrl_t         ctrl;

	// ******************************************************************
	// Input side
	// ******************************************************************
	bank_table u_bank_table (
		.clk32(clk32), .cart_loading(cart_loading), .bank_wr(cart_bank_wr),
		.rec(cart_bank), .lo_index(lo_index), .hi_index(hi_index),
		.lo_bank(lo_bank), .hi_bank(hi_bank), .ocean_b_seen(ocean_b_seen)
	);

	bus_events u_bus_events (
		.clk32(clk32), .reset_n(reset_n), .cart_loading(cart_loading),
		.cart_id(cart_id), .bus(cpu_bus), .ev(ev)
	);

	// ******************************************************************
	// Banking and translation
	// ******************************************************************
	cart_mapper u_cart_mapper (
		.clk32(clk32), .cart_id(cart_id), .cart_exrom(cart_exrom),
		.cart_game(cart_game), .ev(ev), .bus(cpu_bus), .lo_bank(lo_bank),
		.hi_bank(hi_bank), .ocean_b_seen(ocean_b_seen), .lo_index(lo_index),
		.hi_index(hi_index), .ctrl(ctrl)
	);

	addr_translate u_addr_translate (
		.bus(cpu_bus), .ev(ev), .ctrl(ctrl), .reset_n(reset_n),
		.addr_out(addr_out), .mem_write_out(mem_write_out), .mem_ce_out(mem_ce_out)
	);

	assign exrom = ctrl.exrom;  // To the PLA
	assign game = ctrl.game;

endmodule

// ==== design/addr_translate.sv ====
// Address translation
// Redirects ROML, ROMH and IO2 accesses to the CRT image in SDRAM, blocks
// ROML writes in Ultimax mode and opens a memory cycle for IO2 RAM

module addr_translate (
	input  mem_map_pkg::cpu_bus_t          bus,
	input  cart_pkg::bus_event_t           ev,
	input  cart_pkg::map_ctrl_t            ctrl,
	input  logic                           reset_n,
	output logic [mem_map_pkg::addr_w-1:0] addr_out,
	output logic                           mem_write_out,
	output logic                           mem_ce_out
);
	import mem_map_pkg::*;

	logic ultimax;
	logic io2_sel;
	logic io2_ce;

	assign ultimax = ctrl.exrom & ~ctrl.game;

	// IO2 RAM selected for this access direction
	assign io2_sel = bus.io2 & (bus.write ? ctrl.io2_wr_ena : ctrl.io2_ena);

	// I/O cycles carry no ce of their own, open one on the select edge
	assign io2_ce = (ev.io2_wr & ctrl.io2_wr_ena)
		| (ev.io2_stb & ~bus.write & ctrl.io2_ena);

	// ******************************************************************
	// Translation
	// ******************************************************************
	always_comb begin
		addr_out = addr_w'(bus.addr);
		mem_ce_out = bus.ce;

		// No RAM behind ROML in Ultimax mode
		mem_write_out = bus.write & ~(bus.roml & ultimax);

		if (!reset_n) begin
			// Bits 12:0 stay as the CPU drove them
			if (bus.romh & ~bus.write)
				addr_out[addr_w-1:page_lsb] = rom_page(ctrl.bank_hi);
			if (bus.roml & ~bus.write)
				addr_out[addr_w-1:page_lsb] = rom_page(ctrl.bank_lo);
			if (io2_sel)
				addr_out[addr_w-1:page_lsb] = ram_page(ctrl.io2_bank);  // DFxx

			mem_ce_out = bus.ce | io2_ce;
		end
	end

endmodule

// ==== design/cart_mapper.sv ====
// Cartridge banking state machine
// Tracks the EXROM and GAME lines and the bank selects of the cartridge
// type in use, driven by register accesses in the IO1 window

module cart_mapper (
	input  logic                           clk32,
	input  cart_pkg::cart_type_e           cart_id,
	input  logic [7:0]                     cart_exrom,
	input  logic [7:0]                     cart_game,
	input  cart_pkg::bus_event_t           ev,
	input  mem_map_pkg::cpu_bus_t          bus,
	input  logic [mem_map_pkg::bank_w-1:0] lo_bank,
	input  logic [mem_map_pkg::bank_w-1:0] hi_bank,
	input  logic                           ocean_b_seen,
	output logic [cart_pkg::idx_w-1:0]     lo_index,
	output logic [cart_pkg::idx_w-1:0]     hi_index,
	output cart_pkg::map_ctrl_t            ctrl
);
	import mem_map_pkg::*;
	import cart_pkg::*;

	logic [idx_w-1:0] sel_index;  // Table entry in use
	logic             init_step;  // First cycle after restart

	// Both halves always come from the same entry
	assign lo_index = sel_index;
	assign hi_index = sel_index;

	always_ff @(posedge clk32) begin
		init_step <= ev.restart;

		if (ev.restart) begin
			ctrl <= ctrl_reset;
			sel_index <= '0;
		end else begin
			case (cart_id)

				// ******************************************************
				// Generic 8k, 16k or Ultimax, lines from the CRT header
				// ******************************************************
				generic: begin
					ctrl.exrom <= cart_exrom[0];
					ctrl.game <= cart_game[0];
					ctrl.bank_lo <= lo_bank;  // Entry 0
					ctrl.bank_hi <= hi_bank;
				end

				// ******************************************************
				// Simons Basic, two 8k banks
				// ******************************************************
				simons: begin
					if (init_step) begin
						ctrl.exrom <= 1'b0;
						ctrl.game <= 1'b0;
						ctrl.bank_lo <= '0;
						ctrl.bank_hi <= bank_w'(1);
					end
					if (ev.io1_wr)
						ctrl.game <= 1'b0;  // 16k map
					if (ev.io1_rd)
						ctrl.game <= 1'b1;  // 8k map
				end

				// ******************************************************
				// Ocean type 1, bank in DE00 bits 5:0
				// ******************************************************
				ocean: begin
					if (init_step) begin
						ctrl.exrom <= 1'b0;
						ctrl.game <= 1'b0;
					end
					if (ev.io1_wr) begin
						ctrl.bank_lo <= bank_w'(bus.data[5:0]);
						ctrl.bank_hi <= bank_w'(bus.data[5:0]);
					end
					// Type B uses ROML only, A000 stays RAM
					if (ocean_b_seen)
						ctrl.game <= 1'b1;
				end

				// ******************************************************
				// Magic Desk, 8k map, bit 7 switches the cartridge off
				// ******************************************************
				magic_desk: begin
					if (init_step) begin
						ctrl.exrom <= 1'b0;
						ctrl.game <= 1'b1;
						ctrl.bank_lo <= '0;
					end
					if (ev.io1_wr) begin
						ctrl.bank_lo <= bank_w'(bus.data[3:0]);
						ctrl.exrom <= bus.data[7];
					end
				end

				// ******************************************************
				// EasyFlash and XBank, 256 bytes of RAM at DF00
				// ******************************************************
				easyflash, xbank: begin
					if (init_step) begin
						ctrl.io2_bank <= '0;
						ctrl.io2_ena <= 1'b1;
						ctrl.io2_wr_ena <= 1'b1;
						ctrl.exrom <= (cart_id == easyflash);  // EasyFlash boots Ultimax
						ctrl.game <= 1'b0;
					end

					// Selects follow the table one cycle behind the index
					ctrl.bank_lo <= lo_bank;
					ctrl.bank_hi <= hi_bank;

					if (ev.io1_wr) begin
						if (bus.addr[1]) begin
							// DE02 control, boot jumper assumed when bit 2 is clear
							ctrl.game <= bus.data[2] & ~bus.data[0];
							ctrl.exrom <= ~bus.data[1];
						end else begin
							sel_index <= bus.data[idx_w-1:0];  // DE00 bank
						end
					end
				end

				default: ;
			endcase
		end
	end

endmodule

// ==== design/bus_events.sv ====
// Bus event detection
// Finds the rising edges of IO1, IO2 and the load flag, and raises the
// restart event on reset, on a new cartridge id or when loading starts

module bus_events (
	input  logic                  clk32,
	input  logic                  reset_n,
	input  logic                  cart_loading,
	input  cart_pkg::cart_type_e  cart_id,
	input  mem_map_pkg::cpu_bus_t bus,
	output cart_pkg::bus_event_t  ev
);
	import cart_pkg::*;

	logic       old_io1;
	logic       old_io2;
	logic       old_loading;
	cart_type_e old_id;

	// History of the previous cycle
	always_ff @(posedge clk32) begin
		old_io1 <= bus.io1;
		old_io2 <= bus.io2;
		old_loading <= cart_loading;
		old_id <= cart_id;
	end

	// An I/O access counts once, on the rising edge of its select
	always_comb begin
		ev = '0;
		ev.io1_stb = bus.io1 & ~old_io1;
		ev.io2_stb = bus.io2 & ~old_io2;

		ev.io1_wr = ev.io1_stb & bus.write;
		ev.io1_rd = ev.io1_stb & ~bus.write;
		ev.io2_wr = ev.io2_stb & bus.write;

		ev.restart = reset_n                           // Reset is active high
			| (cart_id != old_id)
			| (cart_loading & ~old_loading);
	end

endmodule

// ==== design/bank_table.sv ====
// Bank lookup tables
// Records where each CHIP packet of the CRT image landed, split into the
// low (ROML) and high (ROMH) halves, and spots 512k Ocean images

module bank_table (
	input  logic                           clk32,
	input  logic                           cart_loading,
	input  logic                           bank_wr,
	input  cart_pkg::bank_rec_t            rec,
	input  logic [cart_pkg::idx_w-1:0]     lo_index,
	input  logic [cart_pkg::idx_w-1:0]     hi_index,
	output logic [mem_map_pkg::bank_w-1:0] lo_bank,
	output logic [mem_map_pkg::bank_w-1:0] hi_bank,
	output logic                           ocean_b_seen
);
	import mem_map_pkg::*;
	import cart_pkg::*;

	logic [bank_w-1:0] lo_tab [table_depth];
	logic [bank_w-1:0] hi_tab [table_depth];

	logic [idx_w-1:0]  wr_index;
	logic [bank_w-1:0] rec_bank;
	logic              old_loading;

	assign wr_index = rec.num[idx_w-1:0];
	assign rec_bank = rec.raddr[page_lsb +: bank_w]; // Bits 19:13

	// ******************************************************************
	// Table fill
	// ******************************************************************
	always_ff @(posedge clk32) begin
		if (bank_wr && rec.num < 16'(table_depth)) begin
			if (rec.load_addr <= roml_load_addr) begin
				lo_tab[wr_index] <= rec_bank;
				// 16k packet covers ROMH too
				if (rec.size > bank_size)
					hi_tab[wr_index] <= bank_w'(rec_bank + 1'b1);
			end else begin
				hi_tab[wr_index] <= rec_bank;  // A000 or E000 packet
			end
		end
	end

	// Ocean type B has more than 32 banks, only ROML is banked
	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;
		if (cart_loading & ~old_loading)
			ocean_b_seen <= 1'b0;
		else if (bank_wr && rec.num >= ocean_b_first_bank)
			ocean_b_seen <= 1'b1;
	end

	assign lo_bank = lo_tab[lo_index];
	assign hi_bank = hi_tab[hi_index];

endmodule

// ==== design/cart_pkg.sv ====
// Cartridge definitions
// Type ids from the CRT header, the chip packet record, the bus events
// and the banking state shared by the mapper and the translator

package cart_pkg;

	// Hardware type field of the CRT header
	typedef enum logic [15:0] {
		generic    = 16'd0,
		simons     = 16'd4,
		ocean      = 16'd5,
		magic_desk = 16'd19,
		easyflash  = 16'd32,
		xbank      = 16'd33
	} cart_type_e;

	// ******************************************************************
	// Bank table
	// ******************************************************************
	localparam int table_depth = 64;
	localparam int idx_w = $clog2(table_depth);

	localparam logic [15:0] ocean_b_first_bank = 16'd32; // 512k Ocean images only
	localparam logic [15:0] roml_load_addr = 16'h8000;
	localparam logic [15:0] bank_size = 16'h2000;        // 8k

	// One CHIP packet as the loader hands it over
	typedef struct packed {
		logic [15:0]                      load_addr;
		logic [15:0]                      size;
		logic [15:0]                      num;
		logic [mem_map_pkg::addr_w-1:0]   raddr;     // Where the packet landed
	} bank_rec_t;

	// Single cycle events on the bus
	typedef struct packed {
		logic io1_wr;
		logic io1_rd;
		logic io2_wr;
		logic io1_stb;  // Rising edge of IO1
		logic io2_stb;  // Rising edge of IO2
		logic restart;
	} bus_event_t;

	// Banking state
	typedef struct packed {
		logic                           exrom;
		logic                           game;
		logic [mem_map_pkg::bank_w-1:0] bank_lo;
		logic [mem_map_pkg::bank_w-1:0] bank_hi;
		logic [mem_map_pkg::bank_w-1:0] io2_bank;
		logic                           io2_ena;     // IO2 maps to RAM on reads
		logic                           io2_wr_ena;  // and on writes
	} map_ctrl_t;

	// No cartridge present
	localparam map_ctrl_t ctrl_reset = '{exrom: 1'b1, game: 1'b1, default: '0};

endpackage

// ==== design/mem_map_pkg.sv ====
// C64 bus and SDRAM address map
// CPU side bus bundle and the page tags that place cartridge ROM and RAM
// banks in the translated memory space

package mem_map_pkg;

	// ******************************************************************
	// Address map
	// ******************************************************************
	localparam int addr_w = 25;                // Translated SDRAM address
	localparam int bank_w = 7;                 // One 8k bank number
	localparam int page_lsb = 13;              // Bank offset is 8k
	localparam int page_w = addr_w - page_lsb; // Bits 24:13

	// ROM banks sit at 0x100000, up to 1MB
	localparam logic rom_base_bit = 1'b1;

	// RAM banks sit at 0x010000, up to 64k
	localparam logic [4:0] ram_base = 5'b00001;
	localparam int ram_bank_w = 3;

	// ******************************************************************
	// CPU side of the bus, sampled every clk32 cycle
	// ******************************************************************
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        write;  // Memory write active
		logic        ce;     // Memory cycle enable
		logic        roml;   // 8000-9FFF cartridge window
		logic        romh;   // A000-BFFF or E000-FFFF
		logic        io1;    // DE00-DEFF
		logic        io2;    // DF00-DFFF
	} cpu_bus_t;

	// Page bits of a ROM bank
	function automatic logic [page_w-1:0] rom_page(input logic [bank_w-1:0] bank);
		return page_w'({rom_base_bit, bank});
	endfunction

	// Page bits of a RAM bank, only the low bits count
	function automatic logic [page_w-1:0] ram_page(input logic [bank_w-1:0] bank);
		return page_w'({ram_base, bank[ram_bank_w-1:0]});
	endfunction

endpackage
